//--- src/acq_config.svh
`ifndef ACQ_CONFIG_SVH
`define ACQ_CONFIG_SVH

// one packet word, also one memory data beat
`define ACQ_WORD_W 128

// byte address on the memory command port
`define ACQ_MEM_ADDR_W 26

// burst address, the start_addr field of the header
// memory address is this value times 8
`define ACQ_GEN_ADDR_W 23

// sample count field of the header
`define ACQ_CNT_W 21

// packet word buffer between packetizer and write controller
`define ACQ_FIFO_DEPTH 16

`endif

//--- src/acq_pkt_pkg.sv
`default_nettype none

`include "acq_config.svh"

package acq_pkt_pkg;

    // top two bits of a valid header word
    localparam logic [1:0] HDR_TAG = 2'b01;

    // header word layout, msb first
    typedef struct packed {
        logic [1:0]                 tag;
        // bits 125..85
        logic [40:0]                rsvd_hi;
        logic [`ACQ_CNT_W-1:0]      burst_cnt;
        // bits 63..58
        logic [5:0]                 rsvd_mid;
        logic [`ACQ_GEN_ADDR_W-1:0] start_addr;
        // bits 34..0
        logic [34:0]                rsvd_lo;
    } pkt_hdr_t;

    // a packet word is either read as a header or carried as raw data
    typedef union packed {
        pkt_hdr_t               hdr;
        logic [`ACQ_WORD_W-1:0] raw;
    } pkt_word_u;

endpackage

`default_nettype wire

//--- src/mem_wr_pkg.sv
`default_nettype none

`include "acq_config.svh"

package mem_wr_pkg;

    // address channel of the application write port
    typedef struct packed {
        logic [`ACQ_MEM_ADDR_W-1:0] addr;
        // accepted together with wr_app_rdy
        logic                       en;
    } mem_cmd_t;

    // write data channel
    typedef struct packed {
        logic [`ACQ_WORD_W-1:0] data;
        // accepted together with app_wdf_rdy
        logic                   wren;
        // app_wdf_end, every beat closes its burst here
        logic                   last;
    } mem_wdf_t;

endpackage

`default_nettype wire

//--- src/adc_packetizer.sv
`default_nettype none

`include "acq_config.svh"

module adc_packetizer (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        acq_enabled,
    input  logic                        acq_start,
    input  logic [`ACQ_GEN_ADDR_W-1:0]  start_addr,
    input  logic [`ACQ_CNT_W-1:0]       burst_cnt,
    input  logic [`ACQ_WORD_W-1:0]      adc_sample,
    input  logic                        adc_valid,
    input  logic                        full,
    output logic                        push,
    output acq_pkt_pkg::pkt_word_u      wr_word,
    output logic                        acq_done,
    output logic                        overflow
);
    import acq_pkt_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_HEADER,
        S_SAMPLES,
        S_CHECKSUM,
        S_DONE
    } pk_state_t;

    pk_state_t                  state;
    logic                       start_ok;
    logic [`ACQ_GEN_ADDR_W-1:0] pkt_addr;
    logic [`ACQ_CNT_W-1:0]      pkt_cnt;
    logic [`ACQ_CNT_W-1:0]      remaining;
    logic [`ACQ_WORD_W-1:0]     checksum;

    // a new packet only starts from idle or after the previous one is done
    assign start_ok = acq_enabled && acq_start && (state == S_IDLE || state == S_DONE);

    // sequencer, dropping acq_enabled abandons the packet
    always_ff @(posedge clk) begin
        if (reset || !acq_enabled) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE, S_DONE: begin
                    if (start_ok) begin
                        state <= S_HEADER;
                    end
                end
                // empty packet goes straight to the checksum
                S_HEADER: state <= (pkt_cnt == '0) ? S_CHECKSUM : S_SAMPLES;
                S_SAMPLES: begin
                    if (adc_valid && remaining == `ACQ_CNT_W'(1)) begin
                        state <= S_CHECKSUM;
                    end
                end
                S_CHECKSUM: state <= S_DONE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // packet parameters, sample countdown and running xor
    always_ff @(posedge clk) begin
        if (start_ok) begin
            pkt_addr  <= start_addr;
            pkt_cnt   <= burst_cnt;
            remaining <= burst_cnt;
            checksum  <= '0;
        end else if (state == S_SAMPLES && adc_valid) begin
            remaining <= remaining - 1'b1;
            checksum  <= checksum ^ adc_sample;
        end
    end

    // header, then one word per valid sample, then the checksum
    assign push = (state == S_HEADER) || (state == S_CHECKSUM) ||
                  (state == S_SAMPLES && adc_valid);

    always_comb begin
        wr_word = '0;
        case (state)
            S_HEADER: begin
                wr_word.hdr.tag        = HDR_TAG;
                wr_word.hdr.burst_cnt  = pkt_cnt;
                wr_word.hdr.start_addr = pkt_addr;
            end
            S_CHECKSUM: wr_word.raw = checksum;
            default: wr_word.raw = adc_sample;
        endcase
    end

    // held until the next start so the write side can see it across domains
    assign acq_done = (state == S_DONE);

    // a word of this packet was lost to a full fifo
    always_ff @(posedge clk) begin
        if (reset || start_ok) begin
            overflow <= 1'b0;
        end else if (push && full) begin
            overflow <= 1'b1;
        end
    end

    // sample phase always has a sample left, the countdown never underflows
    a_samples_left: assert property (@(posedge clk) disable iff (reset)
        (state == S_SAMPLES) |-> remaining != '0);

endmodule

`default_nettype wire

//--- src/pkt_fifo.sv
`default_nettype none

`include "acq_config.svh"

module pkt_fifo (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   push,
    input  acq_pkt_pkg::pkt_word_u wr_word,
    input  logic                   pop,
    output acq_pkt_pkg::pkt_word_u head,
    output logic                   empty,
    output logic                   full,
    output logic                   overflow
);
    import acq_pkt_pkg::*;

    localparam int DEPTH = `ACQ_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    pkt_word_u        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // a push into a full buffer is dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));

    // fall-through, the oldest word is always on the head
    assign head = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_word;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // sticky until reset
    always_ff @(posedge clk) begin
        if (reset) begin
            overflow <= 1'b0;
        end else if (push && full) begin
            overflow <= 1'b1;
        end
    end

    // the reader only takes a word it has been shown
    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset) pop |-> !empty);

endmodule

`default_nettype wire

//--- src/ddr3_wr_control.sv
`default_nettype none

`include "acq_config.svh"

module ddr3_wr_control (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   acq_enabled,
    // fifo head, valid whenever empty is low
    input  acq_pkt_pkg::pkt_word_u head,
    input  logic                   empty,
    output logic                   pop,
    // application write port
    output mem_wr_pkg::mem_cmd_t   cmd,
    input  logic                   wr_app_rdy,
    output mem_wr_pkg::mem_wdf_t   wdf,
    input  logic                   app_wdf_rdy,
    output logic [`ACQ_WORD_W-1:0] fill_header_wr_dat,
    output logic                   fill_header_wr_en,
    output logic                   ddr3_wr_sync_err,
    output logic                   ddr3_wr_done,
    // from the packetizer, other clock domain
    input  logic                   acq_done
);
    import acq_pkt_pkg::*;

    // one spare bit so burst_cnt plus 2 can not wrap
    localparam int CNT_W = `ACQ_CNT_W + 1;

    // one-hot state indices
    localparam int IDLE        = 0;
    localparam int TST_HDR_TAG = 1;
    localparam int SYNC_ERR    = 2;
    localparam int INIT        = 3;
    localparam int ADJ_CNT     = 4;
    localparam int WRITE       = 5;
    localparam int WRITE_HDR   = 6;
    localparam int DONE        = 7;

    logic [7:0]                 cs;
    logic [7:0]                 ns;
    logic                       acq_done_meta;
    logic                       acq_done_sync;
    logic                       addr_accept;
    logic                       data_accept;
    logic                       addr_allow;
    logic [`ACQ_WORD_W-1:0]     hdr_latch;
    logic [`ACQ_GEN_ADDR_W-1:0] addr_gen;
    logic [CNT_W-1:0]           addr_cnt;
    logic [CNT_W-1:0]           burst_cnt;
    logic                       addr_cnt_zero;
    logic                       burst_cnt_zero;
    logic [CNT_W-1:0]           addr_credit;
    logic                       latch_header;
    logic                       init_cnt;
    logic                       adjust_cnt;

    // count down on acceptance, parks at zero
    function automatic logic [CNT_W-1:0] count_down(input logic [CNT_W-1:0] cnt,
                                                    input logic dec);
        return (dec && cnt != '0) ? cnt - 1'b1 : cnt;
    endfunction

    // two-flop synchronizer for acq_done
    always_ff @(posedge clk) begin
        if (reset) begin
            acq_done_meta <= 1'b0;
            acq_done_sync <= 1'b0;
        end else begin
            acq_done_meta <= acq_done;
            acq_done_sync <= acq_done_meta;
        end
    end

    assign addr_accept = cmd.en && wr_app_rdy;
    assign data_accept = wdf.wren && app_wdf_rdy;

    // copy of the header for the fill-header port
    always_ff @(posedge clk) begin
        if (latch_header) begin
            hdr_latch <= head.raw;
        end
    end
    assign fill_header_wr_dat = hdr_latch;

    // burst address, loaded from the header and stepped per accepted address
    always_ff @(posedge clk) begin
        if (reset) begin
            addr_gen <= '0;
        end else if (init_cnt) begin
            addr_gen <= head.hdr.start_addr;
        end else if (addr_accept) begin
            addr_gen <= addr_gen + 1'b1;
        end
    end

    // address and burst down-counters
    // plus 2 covers the header and checksum words
    always_ff @(posedge clk) begin
        if (reset) begin
            addr_cnt  <= '0;
            burst_cnt <= '0;
        end else if (init_cnt) begin
            addr_cnt  <= {1'b0, head.hdr.burst_cnt};
            burst_cnt <= {1'b0, head.hdr.burst_cnt};
        end else if (adjust_cnt) begin
            addr_cnt  <= addr_cnt + CNT_W'(2);
            burst_cnt <= burst_cnt + CNT_W'(2);
        end else begin
            addr_cnt  <= count_down(addr_cnt, addr_accept);
            burst_cnt <= count_down(burst_cnt, data_accept);
        end
    end
    assign addr_cnt_zero  = (addr_cnt == '0);
    assign burst_cnt_zero = (burst_cnt == '0);

    // address throttle
    // counts data beats not yet matched by an address
    always_ff @(posedge clk) begin
        if (reset || !acq_enabled) begin
            addr_credit <= '0;
        end else if (data_accept && !addr_accept) begin
            addr_credit <= addr_credit + 1'b1;
        end else if (addr_accept && !data_accept) begin
            addr_credit <= addr_credit - 1'b1;
        end
    end
    // an address only goes out once its data has
    assign addr_allow = (addr_credit != '0);

    always_ff @(posedge clk) begin
        if (reset || !acq_enabled) begin
            cs       <= '0;
            cs[IDLE] <= 1'b1;
        end else begin
            cs <= ns;
        end
    end

    always_comb begin
        ns = '0;
        case (1'b1)
            // fall-through fifo, not empty means the head is valid
            cs[IDLE]: ns[empty ? IDLE : TST_HDR_TAG] = 1'b1;
            // anything but a header tag means we lost packet framing
            cs[TST_HDR_TAG]: ns[(head.hdr.tag == HDR_TAG) ? INIT : SYNC_ERR] = 1'b1;
            // only reset or a disable leaves here
            cs[SYNC_ERR]: ns[SYNC_ERR] = 1'b1;
            cs[INIT]: ns[ADJ_CNT] = 1'b1;
            cs[ADJ_CNT]: ns[WRITE] = 1'b1;
            cs[WRITE]: ns[(addr_cnt_zero && burst_cnt_zero) ? WRITE_HDR : WRITE] = 1'b1;
            cs[WRITE_HDR]: ns[DONE] = 1'b1;
            // wait for the packetizer to report done
            cs[DONE]: ns[acq_done_sync ? IDLE : DONE] = 1'b1;
            default: ns[IDLE] = 1'b1;
        endcase
    end

    // state outputs registered from ns, so they line up with the state
    always_ff @(posedge clk) begin
        if (reset || !acq_enabled) begin
            latch_header      <= 1'b0;
            init_cnt          <= 1'b0;
            adjust_cnt        <= 1'b0;
            fill_header_wr_en <= 1'b0;
            ddr3_wr_sync_err  <= 1'b0;
            ddr3_wr_done      <= 1'b0;
        end else begin
            latch_header      <= ns[TST_HDR_TAG];
            init_cnt          <= ns[INIT];
            adjust_cnt        <= ns[ADJ_CNT];
            fill_header_wr_en <= ns[WRITE_HDR];
            ddr3_wr_sync_err  <= ns[SYNC_ERR];
            ddr3_wr_done      <= ns[DONE];
        end
    end

    // memory word i lands at byte address (start_addr + i) * 8
    assign cmd.addr = {addr_gen, 3'b000};
    assign cmd.en   = cs[WRITE] && addr_allow && !addr_cnt_zero;

    // the whole packet goes out, header included
    assign wdf.data = head.raw;
    assign wdf.wren = cs[WRITE] && !empty && !burst_cnt_zero;
    assign wdf.last = wdf.wren;

    // next word comes forward once the current one is taken
    assign pop = data_accept;

    // the address countdown never runs ahead of the data countdown
    a_addr_behind_data: assert property (@(posedge clk) disable iff (reset)
        cs[WRITE] |-> addr_cnt >= burst_cnt);

    // an unmatched beat always raises the credit, no wrap above the top
    a_credit_no_wrap: assert property (@(posedge clk) disable iff (reset || !acq_enabled)
        (data_accept && !addr_accept) |=> addr_credit > $past(addr_credit));

endmodule

`default_nettype wire

//--- src/acq_write_top.sv
`default_nettype none

`include "acq_config.svh"

module acq_write_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       acq_enabled,
    // adc side
    input  logic                       acq_start,
    input  logic [`ACQ_GEN_ADDR_W-1:0] start_addr,
    input  logic [`ACQ_CNT_W-1:0]      burst_cnt,
    input  logic [`ACQ_WORD_W-1:0]     adc_sample,
    input  logic                       adc_valid,
    // memory application write port
    output mem_wr_pkg::mem_cmd_t       cmd,
    input  logic                       wr_app_rdy,
    output mem_wr_pkg::mem_wdf_t       wdf,
    input  logic                       app_wdf_rdy,
    // fill header and status
    output logic [`ACQ_WORD_W-1:0]     fill_header_wr_dat,
    output logic                       fill_header_wr_en,
    output logic                       ddr3_wr_sync_err,
    output logic                       ddr3_wr_done,
    // fifo overflow, sticky until reset
    output logic                       overflow,
    // a word of the current packet was dropped
    output logic                       pkt_overflow
);
    import acq_pkt_pkg::*;

    pkt_word_u wr_word;
    pkt_word_u head;
    logic      push;
    logic      pop;
    logic      full;
    logic      empty;
    logic      acq_done;

    // stage 1, framing
    adc_packetizer u_adc_packetizer (
        .clk         (clk),
        .reset       (reset),
        .acq_enabled (acq_enabled),
        .acq_start   (acq_start),
        .start_addr  (start_addr),
        .burst_cnt   (burst_cnt),
        .adc_sample  (adc_sample),
        .adc_valid   (adc_valid),
        .full        (full),
        .push        (push),
        .wr_word     (wr_word),
        .acq_done    (acq_done),
        .overflow    (pkt_overflow)
    );

    // stage 2, buffering
    pkt_fifo u_pkt_fifo (
        .clk      (clk),
        .reset    (reset),
        .push     (push),
        .wr_word  (wr_word),
        .pop      (pop),
        .head     (head),
        .empty    (empty),
        .full     (full),
        .overflow (overflow)
    );

    // stage 3, memory writes
    ddr3_wr_control u_ddr3_wr_control (
        .clk                (clk),
        .reset              (reset),
        .acq_enabled        (acq_enabled),
        .head               (head),
        .empty              (empty),
        .pop                (pop),
        .cmd                (cmd),
        .wr_app_rdy         (wr_app_rdy),
        .wdf                (wdf),
        .app_wdf_rdy        (app_wdf_rdy),
        .fill_header_wr_dat (fill_header_wr_dat),
        .fill_header_wr_en  (fill_header_wr_en),
        .ddr3_wr_sync_err   (ddr3_wr_sync_err),
        .ddr3_wr_done       (ddr3_wr_done),
        .acq_done           (acq_done)
    );

endmodule

`default_nettype wire

//--- bench/tb_acq_write.sv
`default_nettype none

`include "acq_config.svh"

module tb_acq_write;
    import mem_wr_pkg::*;

    // responder modes for the two rdy inputs
    localparam int RDY_ALWAYS = 0;
    localparam int RDY_RANDOM = 1;
    localparam int RDY_STALL  = 2;
    // what a wait loop watches
    localparam int SEL_DONE     = 0;
    localparam int SEL_SYNC_ERR = 1;
    localparam int SEL_WRITTEN  = 2;

    logic                       clk;
    logic                       reset       = 1'b1;
    logic                       acq_enabled = 1'b0;
    logic                       acq_start   = 1'b0;
    logic [`ACQ_GEN_ADDR_W-1:0] start_addr  = '0;
    logic [`ACQ_CNT_W-1:0]      burst_cnt   = '0;
    logic [`ACQ_WORD_W-1:0]     adc_sample  = '0;
    logic                       adc_valid   = 1'b0;
    logic                       wr_app_rdy  = 1'b0;
    logic                       app_wdf_rdy = 1'b0;
    mem_cmd_t                   cmd;
    mem_wdf_t                   wdf;
    logic [`ACQ_WORD_W-1:0]     fill_header_wr_dat;
    logic                       fill_header_wr_en;
    logic                       ddr3_wr_sync_err;
    logic                       ddr3_wr_done;
    logic                       overflow;
    logic                       pkt_overflow;

    int                         rdy_mode    = RDY_ALWAYS;
    int                         error_count = 0;
    int                         fill_count  = 0;
    logic [`ACQ_WORD_W-1:0]     fill_dat;
    // accepted beats and addresses, and the expected packet
    logic [`ACQ_WORD_W-1:0]     data_q [$];
    logic [`ACQ_MEM_ADDR_W-1:0] addr_q [$];
    logic [`ACQ_WORD_W-1:0]     exp_q [$];
    // previous cycle, for the hold checks
    logic                       prev_active = 1'b0;
    logic                       prev_wren   = 1'b0;
    logic                       prev_wdf_rdy;
    logic [`ACQ_WORD_W-1:0]     prev_data;
    logic                       prev_en     = 1'b0;
    logic                       prev_cmd_rdy;
    logic [`ACQ_MEM_ADDR_W-1:0] prev_addr;

    acq_write_top u_acq_write_top (
        .clk                (clk),
        .reset              (reset),
        .acq_enabled        (acq_enabled),
        .acq_start          (acq_start),
        .start_addr         (start_addr),
        .burst_cnt          (burst_cnt),
        .adc_sample         (adc_sample),
        .adc_valid          (adc_valid),
        .cmd                (cmd),
        .wr_app_rdy         (wr_app_rdy),
        .wdf                (wdf),
        .app_wdf_rdy        (app_wdf_rdy),
        .fill_header_wr_dat (fill_header_wr_dat),
        .fill_header_wr_en  (fill_header_wr_en),
        .ddr3_wr_sync_err   (ddr3_wr_sync_err),
        .ddr3_wr_done       (ddr3_wr_done),
        .overflow           (overflow),
        .pkt_overflow       (pkt_overflow)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_with_error(input string msg);
        error_count++;
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic logic [`ACQ_WORD_W-1:0] rand_word();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    // header layout: tag 127..126, count 84..64, start address 57..35
    function automatic logic [`ACQ_WORD_W-1:0] make_header(input logic [22:0] addr,
                                                           input int n);
        logic [`ACQ_WORD_W-1:0] w;
        w            = '0;
        w[127:126]   = 2'b01;
        w[84:64]     = 21'(n);
        w[57:35]     = addr;
        return w;
    endfunction

    // memory responder
    always @(posedge clk) begin
        if (reset || rdy_mode == RDY_STALL) begin
            wr_app_rdy  <= 1'b0;
            app_wdf_rdy <= 1'b0;
        end else if (rdy_mode == RDY_RANDOM) begin
            wr_app_rdy  <= 1'($urandom % 2);
            app_wdf_rdy <= 1'($urandom % 2);
        end else begin
            wr_app_rdy  <= 1'b1;
            app_wdf_rdy <= 1'b1;
        end
    end

    // monitor at the falling edge, where the port is stable
    always @(negedge clk) begin
        if (wdf.wren && app_wdf_rdy) begin
            data_q.push_back(wdf.data);
            // every beat closes its own burst
            assert (wdf.last)
                else abort_with_error($sformatf("[FAIL] t=%0t wdf.last expected 1 got %b",
                                                $time, wdf.last));
        end
        if (cmd.en && wr_app_rdy) begin
            addr_q.push_back(cmd.addr);
        end
        if (fill_header_wr_en) begin
            fill_count++;
            fill_dat = fill_header_wr_dat;
        end
        assert (addr_q.size() <= data_q.size())
            else abort_with_error($sformatf("[FAIL] t=%0t accepted addresses expected <= %0d got %0d",
                                            $time, data_q.size(), addr_q.size()));
        // a refused beat stays on the port unchanged
        if (prev_active && acq_enabled && !reset && prev_wren && !prev_wdf_rdy) begin
            assert (wdf.wren && wdf.data == prev_data)
                else abort_with_error($sformatf("[FAIL] t=%0t wdf.data held expected %h got %h",
                                                $time, prev_data, wdf.data));
        end
        if (prev_active && acq_enabled && !reset && prev_en && !prev_cmd_rdy) begin
            assert (cmd.en && cmd.addr == prev_addr)
                else abort_with_error($sformatf("[FAIL] t=%0t cmd.addr held expected %h got %h",
                                                $time, prev_addr, cmd.addr));
        end
        prev_active  = acq_enabled && !reset;
        prev_wren    = wdf.wren;
        prev_wdf_rdy = app_wdf_rdy;
        prev_data    = wdf.data;
        prev_en      = cmd.en;
        prev_cmd_rdy = wr_app_rdy;
        prev_addr    = cmd.addr;
    end

    function automatic bit probe(input int sel);
        case (sel)
            SEL_DONE: return ddr3_wr_done;
            SEL_SYNC_ERR: return ddr3_wr_sync_err;
            default: return data_q.size() != 0;
        endcase
    endfunction

    // returns at a falling edge once the watched bit has the level
    task automatic wait_for(input int sel, input bit level, input int limit, input string what);
        int cycles;
        bit seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < limit) begin
            @(negedge clk);
            seen = (probe(sel) == level);
            cycles++;
        end
        assert (seen)
            else abort_with_error($sformatf("timeout after %0d cycles waiting for %s",
                                            limit, what));
    endtask

    // one cycle start pulse, returns on the first sample cycle
    task automatic start_packet(input logic [22:0] addr, input int n);
        @(posedge clk);
        acq_start  <= 1'b1;
        start_addr <= addr;
        burst_cnt  <= 21'(n);
        @(posedge clk);
        acq_start  <= 1'b0;
        // header cycle
        @(posedge clk);
    endtask

    // samples come from exp_q, optionally with idle gaps
    task automatic feed_samples(input int n, input bit gaps);
        for (int i = 1; i <= n; i++) begin
            adc_valid  <= 1'b1;
            adc_sample <= exp_q[i];
            @(posedge clk);
            if (gaps && ($urandom % 3 == 0)) begin
                adc_valid <= 1'b0;
                @(posedge clk);
            end
        end
        adc_valid <= 1'b0;
    endtask

    task automatic check_packet(input logic [22:0] addr);
        logic [`ACQ_MEM_ADDR_W-1:0] exp_addr;
        assert (data_q.size() == exp_q.size())
            else abort_with_error($sformatf("[FAIL] t=%0t data beats expected %0d got %0d",
                                            $time, exp_q.size(), data_q.size()));
        assert (addr_q.size() == exp_q.size())
            else abort_with_error($sformatf("[FAIL] t=%0t addresses expected %0d got %0d",
                                            $time, exp_q.size(), addr_q.size()));
        for (int i = 0; i < exp_q.size(); i++) begin
            exp_addr = 26'((32'(addr) + i) * 8);
            assert (data_q[i] == exp_q[i])
                else abort_with_error($sformatf("[FAIL] t=%0t wdf.data word %0d expected %h got %h",
                                                $time, i, exp_q[i], data_q[i]));
            assert (addr_q[i] == exp_addr)
                else abort_with_error($sformatf("[FAIL] t=%0t cmd.addr word %0d expected %h got %h",
                                                $time, i, exp_addr, addr_q[i]));
        end
        assert (fill_count == 1)
            else abort_with_error($sformatf("[FAIL] t=%0t fill_header_wr_en pulses expected 1 got %0d",
                                            $time, fill_count));
        assert (fill_dat == exp_q[0])
            else abort_with_error($sformatf("[FAIL] t=%0t fill_header_wr_dat expected %h got %h",
                                            $time, exp_q[0], fill_dat));
        assert (!overflow && !pkt_overflow)
            else abort_with_error($sformatf("[FAIL] t=%0t overflow expected 0 got %b",
                                            $time, overflow | pkt_overflow));
    endtask

    // header, n random samples, xor checksum, then done and back to idle
    task automatic run_packet(input logic [22:0] addr, input int n, input bit gaps);
        logic [`ACQ_WORD_W-1:0] csum;
        logic [`ACQ_WORD_W-1:0] s;
        csum = '0;
        data_q.delete();
        addr_q.delete();
        exp_q.delete();
        fill_count = 0;
        exp_q.push_back(make_header(addr, n));
        for (int i = 0; i < n; i++) begin
            s = rand_word();
            csum ^= s;
            exp_q.push_back(s);
        end
        exp_q.push_back(csum);
        start_packet(addr, n);
        feed_samples(n, gaps);
        wait_for(SEL_DONE, 1'b1, 2000, "ddr3_wr_done to rise");
        check_packet(addr);
        wait_for(SEL_DONE, 1'b0, 20, "ddr3_wr_done to fall after acq_done");
    endtask

    task automatic basic_packet();
        rdy_mode = RDY_ALWAYS;
        run_packet(23'h00_1000, 8, 1'b0);
    endtask

    task automatic random_backpressure();
        rdy_mode = RDY_RANDOM;
        run_packet(23'h12_3450, 12, 1'b1);
        run_packet(23'h00_0077, 5, 1'b1);
        rdy_mode = RDY_ALWAYS;
    endtask

    task automatic empty_packet();
        run_packet(23'h05_5000, 0, 1'b0);
    endtask

    // second start right after the first, the last one wraps the address
    task automatic back_to_back();
        run_packet(23'h20_0000, 6, 1'b0);
        run_packet(23'h7f_fffe, 4, 1'b0);
    endtask

    task automatic sync_error_check();
        int beats;
        int addrs;
        rdy_mode = RDY_ALWAYS;
        data_q.delete();
        addr_q.delete();
        exp_q.delete();
        exp_q.push_back(make_header(23'h03_0000, 8));
        // top bits 11 can never pass as a header tag
        for (int i = 0; i < 4; i++) begin
            exp_q.push_back({2'b11, 126'(rand_word())});
        end
        start_packet(23'h03_0000, 8);
        wait_for(SEL_WRITTEN, 1'b1, 50, "the header write");
        rdy_mode = RDY_STALL;
        repeat (2) @(posedge clk);
        // samples pile up in the fifo behind the header
        feed_samples(4, 1'b0);
        acq_enabled <= 1'b0;
        repeat (3) @(posedge clk);
        acq_enabled <= 1'b1;
        wait_for(SEL_SYNC_ERR, 1'b1, 50, "ddr3_wr_sync_err to rise");
        beats = data_q.size();
        addrs = addr_q.size();
        rdy_mode = RDY_ALWAYS;
        repeat (20) @(posedge clk);
        assert (data_q.size() == beats && addr_q.size() == addrs)
            else abort_with_error($sformatf("[FAIL] t=%0t writes after sync error expected %0d got %0d",
                                            $time, beats + addrs, data_q.size() + addr_q.size()));
        assert (ddr3_wr_sync_err)
            else abort_with_error($sformatf("[FAIL] t=%0t ddr3_wr_sync_err expected 1 got %b",
                                            $time, ddr3_wr_sync_err));
    endtask

    initial begin
        void'($urandom(98171));
        repeat (10) @(posedge clk);
        reset       <= 1'b0;
        acq_enabled <= 1'b1;
        repeat (2) @(posedge clk);
        basic_packet();
        random_backpressure();
        empty_packet();
        back_to_back();
        sync_error_check();
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+src
src/acq_pkt_pkg.sv
src/mem_wr_pkg.sv
src/adc_packetizer.sv
src/pkt_fifo.sv
src/ddr3_wr_control.sv
src/acq_write_top.sv
bench/tb_acq_write.sv

//--- Makefile
# Verilator build and run of the ADC capture write path

TOP := tb_acq_write

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP) \
		-Mdir obj_dir -o sim_$(TOP)

run: compile
	-./obj_dir/sim_$(TOP) 2>&1 | tee sim.log
	@if grep -q "STATUS: FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "STATUS: PASS" sim.log; then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
